//--- dv/rv_int_slice_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_slice_checker
    import rv_core_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         res_ready,
    input logic         res_valid,
    input result_kind_e res_kind,
    input reg_idx_t     res_rd,
    input xlen_t        res_data,
    input logic         res_redirect,
    input xlen_t        res_target
);

    a_valid_after_reset: assert property (@(posedge clk) reset |=> !res_valid)
        else $error("res_valid high in the cycle after reset");

    a_redirect_is_branch: assert property (@(posedge clk) disable iff (reset)
        res_redirect |-> (res_valid && res_kind == RES_BRANCH))
        else $error("redirect without a branch result");

    // everything held while the consumer stalls
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_kind) && $stable(res_rd)
            && $stable(res_data) && $stable(res_redirect) && $stable(res_target)))
        else $error("result ports changed under stall");

endmodule

bind rv_int_slice rv_int_slice_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .res_ready    (res_ready),
    .res_valid    (res_valid),
    .res_kind     (res_kind),
    .res_rd       (res_rd),
    .res_data     (res_data),
    .res_redirect (res_redirect),
    .res_target   (res_target)
);

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/tb_rv_int_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_int_slice
    import rv_core_pkg::*;
();

    localparam int NUM_PACKETS = 2000;
    localparam int CLK_PERIOD  = 4;

    typedef struct packed {
        result_kind_e kind;
        reg_idx_t     rd;
        xlen_t        data;
        logic         redirect;
        xlen_t        target;
        logic [31:0]  adv;
    } exp_t;

    logic         clk;
    logic         reset;
    logic         in_valid;
    instr_t       in_instr;
    xlen_t        in_pc;
    logic         res_ready;
    logic         in_ready;
    logic         res_valid;
    result_kind_e res_kind;
    reg_idx_t     res_rd;
    xlen_t        res_data;
    logic         res_redirect;
    xlen_t        res_target;

    logic [31:0] rng;
    xlen_t       mregs [NUM_REGS];
    exp_t        expq [$];
    int          mismatches;
    int          other_errors;
    int          accepted;
    logic [31:0] adv_count;
    logic        prev_taken;
    logic        prev_stall;
    exp_t        held;
    xlen_t       next_pc;

    tb_clock i_clock (.clk(clk));

    rv_int_slice i_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .res_ready    (res_ready),
        .in_ready     (in_ready),
        .res_valid    (res_valid),
        .res_kind     (res_kind),
        .res_rd       (res_rd),
        .res_data     (res_data),
        .res_redirect (res_redirect),
        .res_target   (res_target)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_kind(input string name, input result_kind_e got, input result_kind_e exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_target(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // architectural reference, RV64I semantics
    task automatic run_model(input instr_t ins, input xlen_t pc, output exp_t e);
        opcode_t    opc;
        funct3_t    f3;
        xlen_t      a;
        xlen_t      b;
        xlen_t      r;
        logic [5:0] sh;
        logic [31:0] w;
        logic       word;
        opc  = ins[6:0];
        f3   = ins[14:12];
        a    = (ins[19:15] == 0) ? '0 : mregs[ins[19:15]];
        word = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
        e    = '0;
        if (opc == OPC_OP || opc == OPC_OP_32 || opc == OPC_BRANCH) begin
            b = (ins[24:20] == 0) ? '0 : mregs[ins[24:20]];
        end else begin
            b = {{52{ins[31]}}, ins[31:20]};
        end
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        if (opc == OPC_BRANCH) begin
            e.kind   = RES_BRANCH;
            e.target = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            case (f3)
                3'd0:    e.redirect = (a == b);
                3'd1:    e.redirect = (a != b);
                3'd4:    e.redirect = ($signed(a) < $signed(b));
                3'd5:    e.redirect = ($signed(a) >= $signed(b));
                3'd6:    e.redirect = (a < b);
                default: e.redirect = (a >= b);
            endcase
        end else if (opc == OPC_OP || opc == OPC_OP_32 || opc == OPC_OP_IMM
                     || opc == OPC_OP_IMM_32) begin
            case (f3)
                3'd0: r = ((opc == OPC_OP || opc == OPC_OP_32) && ins[30]) ? a - b : a + b;
                3'd1: r = a << sh;
                3'd2: r = {63'd0, $signed(a) < $signed(b)};
                3'd3: r = {63'd0, a < b};
                3'd4: r = a ^ b;
                3'd5: begin
                    if (word) begin
                        if (ins[30]) begin
                            w = $signed(a[31:0]) >>> sh[4:0];
                        end else begin
                            w = a[31:0] >> sh[4:0];
                        end
                        r = {32'd0, w};
                    end else if (ins[30]) begin
                        r = $signed(a) >>> sh;
                    end else begin
                        r = a >> sh;
                    end
                end
                3'd6: r = a | b;
                default: r = a & b;
            endcase
            if (word) begin
                r = {{32{r[31]}}, r[31:0]};
            end
            e.kind = RES_REG;
            e.rd   = ins[11:7];
            e.data = r;
            if (ins[11:7] != 0) begin
                mregs[ins[11:7]] = r;
            end
        end else begin
            e.kind = RES_NONE;
        end
    endtask

    task automatic make_packet(output instr_t ins);
        logic [31:0] r;
        logic [31:0] r2;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        funct3_t     f3;
        logic [11:0] imm;
        logic [12:0] b;
        opcode_t     opc;
        rng = xorshift(rng);
        r   = rng;
        rng = xorshift(rng);
        r2  = rng;
        // eight registers keep dependencies dense
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        if (accepted < 7) begin
            ins = {r2[11:0], 5'd0, 3'd0, 5'(accepted + 1), OPC_OP_IMM};
        end else if (r[15:12] < 6) begin
            opc = r2[0] ? OPC_OP_32 : OPC_OP;
            if (opc == OPC_OP_32) begin
                f3 = (r2[2:1] == 0) ? 3'd0 : (r2[2:1] == 1) ? 3'd1 : 3'd5;
            end
            ins = {((f3 == 0 || f3 == 5) && r2[3]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opc};
        end else if (r[15:12] < 11) begin
            opc = r2[0] ? OPC_OP_IMM_32 : OPC_OP_IMM;
            imm = r2[15:4];
            if (opc == OPC_OP_IMM_32) begin
                f3 = (r2[2:1] == 0) ? 3'd0 : (r2[2:1] == 1) ? 3'd1 : 3'd5;
            end
            if (f3 == 1 || f3 == 5) begin
                imm[11:6] = (f3 == 5 && r2[16]) ? 6'b010000 : 6'b000000;
                if (opc == OPC_OP_IMM_32) begin
                    imm[5] = 1'b0;
                end
            end
            ins = {imm, rs1, f3, rd, opc};
        end else if (r[15:12] < 14) begin
            f3 = (r2[2:0] == 2) ? 3'd0 : (r2[2:0] == 3) ? 3'd1 : r2[2:0];
            b  = {r2[15:4], 1'b0};
            ins = {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
        end else begin
            case (r2[2:0])
                3'd0:    opc = 7'b0000011;
                3'd1:    opc = 7'b0100011;
                3'd2:    opc = 7'b1101111;
                3'd3:    opc = 7'b1100111;
                3'd4:    opc = 7'b0110111;
                3'd5:    opc = 7'b0010111;
                3'd6:    opc = 7'b0001111;
                default: opc = 7'b1110011;
            endcase
            ins = {r[31:7], opc};
        end
    endtask

    // evaluated mid-cycle, decides what the next edge does
    task automatic eval_cycle();
        exp_t e;
        exp_t cur;
        if (in_ready !== res_ready) begin
            $display("in_ready does not follow res_ready at %0t", $time);
            other_errors++;
        end
        cur = '{res_kind, res_rd, res_data, res_redirect, res_target, 32'd0};
        if (prev_stall) begin
            check_flag("res_valid", res_valid, 1'b1);
            check_kind("res_kind", res_kind, held.kind);
            check_reg("res_rd", res_rd, held.rd);
            check_data("res_data", res_data, held.data);
            check_flag("res_redirect", res_redirect, held.redirect);
            check_target("res_target", res_target, held.target);
        end
        prev_stall = res_valid && !res_ready;
        held = cur;
        if (!res_ready) begin
            return;
        end
        adv_count++;
        if (res_valid) begin
            if (expq.size() == 0) begin
                $display("result seen with nothing outstanding at %0t", $time);
                other_errors++;
            end else begin
                e = expq.pop_front();
                if (e.adv + 2 != adv_count) begin
                    $display("result latency wrong at %0t", $time);
                    other_errors++;
                end
                check_kind("res_kind", res_kind, e.kind);
                check_flag("res_redirect", res_redirect, e.redirect);
                if (e.kind == RES_REG) begin
                    check_reg("res_rd", res_rd, e.rd);
                    check_data("res_data", res_data, e.data);
                end
                if (e.kind == RES_BRANCH) begin
                    check_target("res_target", res_target, e.target);
                end
            end
        end else if (expq.size() != 0 && expq[0].adv + 2 == adv_count) begin
            $display("expected result did not appear at %0t", $time);
            other_errors++;
        end
        if (prev_taken) begin
            prev_taken = 1'b0;
            if (in_valid) begin
                accepted++;
            end
        end else if (in_valid) begin
            accepted++;
            run_model(in_instr, in_pc, e);
            e.adv = adv_count;
            expq.push_back(e);
            prev_taken = e.redirect;
            next_pc = in_pc + 4;
        end
    endtask

    initial begin
        #(10 * NUM_PACKETS * CLK_PERIOD);
        $display("watchdog expired with %0d packets accepted", accepted);
        $display("Checks failed");
        $finish;
    end

    initial begin
        instr_t ins;
        int     idle;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        in_pc        = 64'h0000_0000_8000_0000;
        next_pc      = 64'h0000_0000_8000_0000;
        res_ready    = 1'b1;
        rng          = 32'h4f4d;
        mismatches   = 0;
        other_errors = 0;
        accepted     = 0;
        adv_count    = 0;
        prev_taken   = 1'b0;
        prev_stall   = 1'b0;
        held         = '0;
        idle         = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        while (idle < 4) begin
            rng = xorshift(rng);
            in_pc = next_pc;
            res_ready = (rng[1:0] != 2'b00) || (accepted < 7);
            if (accepted < NUM_PACKETS) begin
                in_valid = (rng[5:2] != 4'd0);
                make_packet(ins);
                in_instr = ins;
            end else begin
                in_valid  = 1'b0;
                res_ready = 1'b1;
                if (expq.size() == 0) begin
                    idle++;
                end
            end
            @(negedge clk);
            eval_cycle();
            @(posedge clk);
            #1;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [6:0]  opcode_t;

    localparam int NUM_REGS = 32;

    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;

    typedef enum logic [1:0] {
        OP_REG,
        OP_IMM,
        OP_ZERO,
        OP_INVD
    } op_type_e;

    typedef struct packed {
        reg_idx_t idx;
        op_type_e optype;
        logic     word;
    } operand_t;

    typedef enum logic [4:0] {
        U_ADD, U_SUB, U_SLL, U_SLT, U_SLTU, U_XOR, U_SRL, U_SRA, U_OR, U_AND,
        U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU,
        U_NONE
    } uop_e;

    typedef struct packed {
        uop_e     uop;
        operand_t dst;
        operand_t src1;
        operand_t src2;
        logic     word;
        xlen_t    imm;
        xlen_t    pc;
    } uinstr_t;

    typedef enum logic [1:0] {
        RES_NONE,
        RES_REG,
        RES_BRANCH
    } result_kind_e;

    function automatic xlen_t sext_i_imm(instr_t instr);
        return {{52{instr[31]}}, instr[31:20]};
    endfunction

    // 13-bit branch offset, bit 0 always zero
    function automatic xlen_t sext_b_imm(instr_t instr);
        return {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    function automatic uop_e decode_uop(instr_t instr);
        opcode_t opc;
        funct3_t f3;
        funct7_t f7;
        uop_e    alu;
        uop_e    u;
        logic    f7_ok;
        logic    w_ok;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        // funct7 0x20 only legal for sub and sra
        f7_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        w_ok  = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
        case (f3)
            3'd0:    alu = ((opc == OPC_OP || opc == OPC_OP_32) && f7[5]) ? U_SUB : U_ADD;
            3'd1:    alu = U_SLL;
            3'd2:    alu = U_SLT;
            3'd3:    alu = U_SLTU;
            3'd4:    alu = U_XOR;
            3'd5:    alu = f7[5] ? U_SRA : U_SRL;
            3'd6:    alu = U_OR;
            default: alu = U_AND;
        endcase
        u = U_NONE;
        case (opc)
            OPC_OP:        if (f7_ok) u = alu;
            OPC_OP_32:     if (f7_ok && w_ok) u = alu;
            OPC_OP_IMM:    u = alu;
            OPC_OP_IMM_32: if (w_ok) u = alu;
            OPC_BRANCH: begin
                case (f3)
                    3'd0:    u = U_BEQ;
                    3'd1:    u = U_BNE;
                    3'd4:    u = U_BLT;
                    3'd5:    u = U_BGE;
                    3'd6:    u = U_BLTU;
                    3'd7:    u = U_BGEU;
                    default: u = U_NONE;
                endcase
            end
            default:       u = U_NONE;
        endcase
        return u;
    endfunction

endpackage

`default_nettype wire

//--- logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_core_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    input  instr_t in_instr,
    input  xlen_t  in_pc,
    uop_if.decode  de
);

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     is_word;
    uinstr_t  uinstr_d;

    logic     de1_valid;
    uinstr_t  de1_uinstr;

    always_comb begin
        opcode  = in_instr[6:0];
        rd      = in_instr[11:7];
        rs1     = in_instr[19:15];
        rs2     = in_instr[24:20];
        is_word = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM_32);

        uinstr_d      = '0;
        uinstr_d.uop  = decode_uop(in_instr);
        uinstr_d.pc   = in_pc;
        uinstr_d.dst  = '{idx: '0, optype: OP_INVD, word: 1'b0};
        uinstr_d.src1 = '{idx: '0, optype: OP_INVD, word: 1'b0};
        uinstr_d.src2 = '{idx: '0, optype: OP_INVD, word: 1'b0};

        case (opcode)
            OPC_OP, OPC_OP_32: begin
                uinstr_d.word = is_word;
                uinstr_d.dst  = '{idx: rd,  optype: OP_REG, word: is_word};
                uinstr_d.src1 = '{idx: rs1, optype: OP_REG, word: is_word};
                uinstr_d.src2 = '{idx: rs2, optype: OP_REG, word: is_word};
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                uinstr_d.word = is_word;
                uinstr_d.dst  = '{idx: rd,  optype: OP_REG, word: is_word};
                uinstr_d.src1 = '{idx: rs1, optype: OP_REG, word: is_word};
                uinstr_d.src2 = '{idx: '0,  optype: OP_IMM, word: is_word};
                uinstr_d.imm  = sext_i_imm(in_instr);
            end
            OPC_BRANCH: begin
                // no destination, full 64-bit compare
                uinstr_d.src1 = '{idx: rs1, optype: OP_REG, word: 1'b0};
                uinstr_d.src2 = '{idx: rs2, optype: OP_REG, word: 1'b0};
                uinstr_d.imm  = sext_b_imm(in_instr);
            end
            default: begin
                // unsupported, flows through as a no-op
            end
        endcase

        // x0 reads become constant zero, never bypassed
        if (uinstr_d.src1.optype == OP_REG && uinstr_d.src1.idx == '0) begin
            uinstr_d.src1.optype = OP_ZERO;
        end
        if (uinstr_d.src2.optype == OP_REG && uinstr_d.src2.idx == '0) begin
            uinstr_d.src2.optype = OP_ZERO;
        end
    end

    // DE1 register
    always_ff @(posedge clk) begin
        if (reset) begin
            de1_valid <= 1'b0;
        end else if (de.advance) begin
            de1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (de.advance) begin
            de1_uinstr <= uinstr_d;
        end
    end

    // younger op squashed while a taken branch retires
    assign de.valid  = de1_valid & ~de.kill;
    assign de.uinstr = de1_uinstr;

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
    import rv_core_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         advance,
    input  logic         kill,
    uop_if.execute       de,
    input  logic         wr_en,
    input  reg_idx_t     wr_idx,
    input  xlen_t        wr_data,
    output logic         ex_valid,
    output result_kind_e ex_kind,
    output reg_idx_t     ex_rd,
    output xlen_t        ex_data,
    output logic         ex_redirect,
    output xlen_t        ex_target
);

    xlen_t        rf_a;
    xlen_t        rf_b;
    xlen_t        src_a;
    xlen_t        src_b;
    logic [5:0]   shamt;
    logic [31:0]  srl_w;
    logic [31:0]  sra_w;
    xlen_t        sra_d;
    xlen_t        alu_raw;
    xlen_t        alu_res;
    logic         is_branch;
    logic         taken;
    result_kind_e kind_d;

    function automatic xlen_t pick_src(operand_t op, xlen_t imm, xlen_t rf_val,
                                       logic byp_en, reg_idx_t byp_idx, xlen_t byp_val);
        case (op.optype)
            OP_IMM:  return imm;
            OP_REG:  return (byp_en && byp_idx == op.idx) ? byp_val : rf_val;
            default: return '0;
        endcase
    endfunction

    rv_regfile i_regfile (
        .clk       (clk),
        .rd_idx_a  (de.uinstr.src1.idx),
        .rd_idx_b  (de.uinstr.src2.idx),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    assign de.advance = advance;
    assign de.kill    = kill;

    // retiring result overrides the stale file entry
    assign src_a = pick_src(de.uinstr.src1, de.uinstr.imm, rf_a, wr_en, wr_idx, wr_data);
    assign src_b = pick_src(de.uinstr.src2, de.uinstr.imm, rf_b, wr_en, wr_idx, wr_data);

    always_comb begin
        shamt = de.uinstr.word ? {1'b0, src_b[4:0]} : src_b[5:0];
        srl_w = src_a[31:0] >> shamt[4:0];
        sra_w = $signed(src_a[31:0]) >>> shamt[4:0];
        sra_d = $signed(src_a) >>> shamt;
        case (de.uinstr.uop)
            U_ADD:   alu_raw = src_a + src_b;
            U_SUB:   alu_raw = src_a - src_b;
            U_SLL:   alu_raw = src_a << shamt;
            U_SLT:   alu_raw = {63'd0, $signed(src_a) < $signed(src_b)};
            U_SLTU:  alu_raw = {63'd0, src_a < src_b};
            U_XOR:   alu_raw = src_a ^ src_b;
            U_SRL:   alu_raw = de.uinstr.word ? {32'd0, srl_w} : src_a >> shamt;
            U_SRA:   alu_raw = de.uinstr.word ? {32'd0, sra_w} : sra_d;
            U_OR:    alu_raw = src_a | src_b;
            U_AND:   alu_raw = src_a & src_b;
            default: alu_raw = '0;
        endcase
        // W forms sign-extend bit 31
        alu_res = de.uinstr.word ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;
    end

    always_comb begin
        is_branch = 1'b1;
        case (de.uinstr.uop)
            U_BEQ:   taken = (src_a == src_b);
            U_BNE:   taken = (src_a != src_b);
            U_BLT:   taken = ($signed(src_a) < $signed(src_b));
            U_BGE:   taken = ($signed(src_a) >= $signed(src_b));
            U_BLTU:  taken = (src_a < src_b);
            U_BGEU:  taken = (src_a >= src_b);
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
        if (de.uinstr.uop == U_NONE) begin
            kind_d = RES_NONE;
        end else if (is_branch) begin
            kind_d = RES_BRANCH;
        end else begin
            kind_d = RES_REG;
        end
    end

    // EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid    <= 1'b0;
            ex_kind     <= RES_NONE;
            ex_redirect <= 1'b0;
        end else if (advance) begin
            ex_valid    <= de.valid;
            ex_kind     <= de.valid ? kind_d : RES_NONE;
            ex_redirect <= de.valid & taken;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rd     <= (kind_d == RES_REG) ? de.uinstr.dst.idx : '0;
            ex_data   <= (kind_d == RES_REG) ? alu_res : '0;
            ex_target <= is_branch ? de.uinstr.pc + de.uinstr.imm : '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_int_slice.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_slice
    import rv_core_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  instr_t       in_instr,
    input  xlen_t        in_pc,
    input  logic         res_ready,
    output logic         in_ready,
    output logic         res_valid,
    output result_kind_e res_kind,
    output reg_idx_t     res_rd,
    output xlen_t        res_data,
    output logic         res_redirect,
    output xlen_t        res_target
);

    logic         ex_valid;
    result_kind_e ex_kind;
    reg_idx_t     ex_rd;
    xlen_t        ex_data;
    logic         ex_redirect;
    xlen_t        ex_target;
    logic         wr_en;
    reg_idx_t     wr_idx;
    xlen_t        wr_data;
    logic         kill;

    uop_if de_if ();

    // whole pipe moves in lockstep with the consumer
    assign in_ready = res_ready;

    rv_decode i_decode (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .de       (de_if.decode)
    );

    rv_execute i_execute (
        .clk         (clk),
        .reset       (reset),
        .advance     (res_ready),
        .kill        (kill),
        .de          (de_if.execute),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .ex_valid    (ex_valid),
        .ex_kind     (ex_kind),
        .ex_rd       (ex_rd),
        .ex_data     (ex_data),
        .ex_redirect (ex_redirect),
        .ex_target   (ex_target)
    );

    rv_retire i_retire (
        .res_ready    (res_ready),
        .ex_valid     (ex_valid),
        .ex_kind      (ex_kind),
        .ex_rd        (ex_rd),
        .ex_data      (ex_data),
        .ex_redirect  (ex_redirect),
        .ex_target    (ex_target),
        .res_valid    (res_valid),
        .res_kind     (res_kind),
        .res_rd       (res_rd),
        .res_data     (res_data),
        .res_redirect (res_redirect),
        .res_target   (res_target),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .kill         (kill)
    );

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output xlen_t    rd_data_a,
    output xlen_t    rd_data_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // entry 0 is never written, so mux it out
    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- logic/rv_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rv_retire
    import rv_core_pkg::*;
(
    input  logic         res_ready,
    input  logic         ex_valid,
    input  result_kind_e ex_kind,
    input  reg_idx_t     ex_rd,
    input  xlen_t        ex_data,
    input  logic         ex_redirect,
    input  xlen_t        ex_target,
    output logic         res_valid,
    output result_kind_e res_kind,
    output reg_idx_t     res_rd,
    output xlen_t        res_data,
    output logic         res_redirect,
    output xlen_t        res_target,
    output logic         wr_en,
    output reg_idx_t     wr_idx,
    output xlen_t        wr_data,
    output logic         kill
);

    logic consume;

    assign consume = ex_valid & res_ready;

    assign res_valid    = ex_valid;
    assign res_kind     = ex_kind;
    assign res_rd       = ex_rd;
    assign res_data     = ex_data;
    assign res_redirect = ex_redirect;
    assign res_target   = ex_target;

    // architectural update only on the consuming edge
    assign wr_en   = consume && (ex_kind == RES_REG);
    assign wr_idx  = ex_rd;
    assign wr_data = ex_data;

    // same edge moves DE1 into EX, so the squash lines up
    assign kill = consume & ex_redirect;

endmodule

`default_nettype wire

//--- logic/uop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uop_if
    import rv_core_pkg::*;
();

    logic    valid;
    uinstr_t uinstr;
    // global enable and mispredict kill, both come back from execute
    logic    advance;
    logic    kill;

    modport decode (
        output valid,
        output uinstr,
        input  advance,
        input  kill
    );

    modport execute (
        input  valid,
        input  uinstr,
        output advance,
        output kill
    );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compile and run the rv_int_slice testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_int_slice \
    -f rv_int_slice.f \
    -o sim_tb_rv_int_slice
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb_rv_int_slice 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

//--- rv_int_slice.f
logic/rv_core_pkg.sv
logic/uop_if.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_retire.sv
logic/rv_int_slice.sv
dv/tb_clock.sv
dv/rv_int_slice_checker.sv
dv/tb_rv_int_slice.sv
